/* include/sq_consts.svh */
`ifndef SQ_CONSTS_SVH
`define SQ_CONSTS_SVH

// Store queue depth and slot index width
`define SQ_ENTRIES 8
`define SQ_SLOT_W 3

// Global program-order number width
`define SQN_W 7

// Store sequence count carries one extra bit so that wrap shows
`define STORE_SQN_W 4

// Register and memory word width
`define XLEN 32

`endif

/* design/coreSeqPkg.sv */
`include "sq_consts.svh"

package coreSeqPkg;

    // Program-order number of any instruction
    // Age is decided by the sign of the difference of two numbers
    typedef logic [`SQN_W-1:0] sqN_t;

    // Running count of stores in program order
    // Its low bits select the queue slot
    typedef logic [`STORE_SQN_W-1:0] storeSqN_t;

    // Slot index within the store queue
    typedef logic [`SQ_SLOT_W-1:0] slotIdx_t;

endpackage

/* design/memAccessPkg.sv */
`include "sq_consts.svh"

package memAccessPkg;

    typedef logic [`XLEN-1:0] byteAddr_t;
    typedef logic [`XLEN-3:0] wordAddr_t;
    typedef logic [3:0] byteMask_t;
    typedef logic [`XLEN-1:0] word_t;

    // 0 is byte, 1 is halfword, 2 is word
    typedef logic [1:0] accessSize_t;

    // Byte lanes touched by an access within its word
    function automatic byteMask_t byteMaskOf(input logic [1:0] lowAddr,
                                             input accessSize_t size);
        byteMask_t mask;
        case (size)
            2'd0: mask = byteMask_t'(4'b0001 << lowAddr);
            2'd1: mask = lowAddr[1] ? 4'b1100 : 4'b0011;
            default: mask = 4'b1111;
        endcase
        return mask;
    endfunction

endpackage

/* design/sqEntryTable.sv */
`include "sq_consts.svh"

module sqEntryTable (
    input  logic                                          clk,
    input  logic                                          rst,

    input  logic                                          enqValid,
    input  coreSeqPkg::sqN_t                              enqSqN,
    input  coreSeqPkg::storeSqN_t                         enqStoreSqN,

    input  logic                                          addrValid,
    input  coreSeqPkg::storeSqN_t                         addrStoreSqN,
    input  memAccessPkg::byteAddr_t                       addrByte,
    input  memAccessPkg::accessSize_t                     addrSize,
    input  memAccessPkg::word_t                           addrData,

    input  coreSeqPkg::sqN_t                              curSqN,

    input  logic                                          branchValid,
    input  coreSeqPkg::sqN_t                              branchSqN,

    input  logic                                          deqValid,
    input  coreSeqPkg::slotIdx_t                          headIdx,

    output logic [`SQ_ENTRIES-1:0]                        entryValid,
    output logic [`SQ_ENTRIES-1:0]                        entryReady,
    output logic [`SQ_ENTRIES-1:0]                        entryAddrAvail,
    output coreSeqPkg::sqN_t [`SQ_ENTRIES-1:0]            entrySqN,
    output memAccessPkg::wordAddr_t [`SQ_ENTRIES-1:0]     entryAddr,
    output memAccessPkg::byteMask_t [`SQ_ENTRIES-1:0]     entryMask,
    output memAccessPkg::word_t [`SQ_ENTRIES-1:0]         entryData
);

    coreSeqPkg::slotIdx_t enqIdx;
    coreSeqPkg::slotIdx_t addrIdx;
    memAccessPkg::byteMask_t addrMask;
    memAccessPkg::word_t addrLaneData;

    assign enqIdx = enqStoreSqN[`SQ_SLOT_W-1:0];
    assign addrIdx = addrStoreSqN[`SQ_SLOT_W-1:0];

    // Register data arrives in the low bits and moves to its byte lanes here
    assign addrMask = memAccessPkg::byteMaskOf(addrByte[1:0], addrSize);
    assign addrLaneData = addrData << {addrByte[1:0], 3'b000};

    // Control bits per slot
    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
            entryReady <= '0;
            entryAddrAvail <= '0;
        end else begin
            // Commit marking once the core's commit number passes the store
            for (int i = 0; i < `SQ_ENTRIES; i++) begin
                if (entryValid[i] &&
                    $signed(coreSeqPkg::sqN_t'(curSqN - entrySqN[i])) > 0) begin
                    entryReady[i] <= 1'b1;
                end
            end

            // Mispredict drops uncommitted stores younger than the branch
            if (branchValid) begin
                for (int i = 0; i < `SQ_ENTRIES; i++) begin
                    if (!entryReady[i] &&
                        $signed(coreSeqPkg::sqN_t'(entrySqN[i] - branchSqN)) > 0) begin
                        entryValid[i] <= 1'b0;
                        entryAddrAvail[i] <= 1'b0;
                    end
                end
            end

            // Head slot leaves when the retire logic takes it
            if (deqValid) begin
                entryValid[headIdx] <= 1'b0;
                entryReady[headIdx] <= 1'b0;
                entryAddrAvail[headIdx] <= 1'b0;
            end

            if (addrValid) begin
                entryAddrAvail[addrIdx] <= 1'b1;
            end

            // A new store starts unaddressed and uncommitted
            if (enqValid) begin
                entryValid[enqIdx] <= 1'b1;
                entryReady[enqIdx] <= 1'b0;
                entryAddrAvail[enqIdx] <= 1'b0;
            end
        end
    end

    // Payload per slot
    always_ff @(posedge clk) begin
        if (enqValid) begin
            entrySqN[enqIdx] <= enqSqN;
        end
        if (addrValid) begin
            entryAddr[addrIdx] <= addrByte[`XLEN-1:2];
            entryMask[addrIdx] <= addrMask;
            entryData[addrIdx] <= addrLaneData;
        end
    end

endmodule

/* design/sqRetire.sv */
`include "sq_consts.svh"

module sqRetire (
    input  logic                                          clk,
    input  logic                                          rst,

    input  logic [`SQ_ENTRIES-1:0]                        entryValid,
    input  logic [`SQ_ENTRIES-1:0]                        entryReady,
    input  logic [`SQ_ENTRIES-1:0]                        entryAddrAvail,
    input  memAccessPkg::wordAddr_t [`SQ_ENTRIES-1:0]     entryAddr,
    input  memAccessPkg::byteMask_t [`SQ_ENTRIES-1:0]     entryMask,
    input  memAccessPkg::word_t [`SQ_ENTRIES-1:0]         entryData,

    output coreSeqPkg::slotIdx_t                          headIdx,
    output logic                                          deqValid,

    output logic                                          stValid,
    output memAccessPkg::wordAddr_t                       stAddr,
    output memAccessPkg::byteMask_t                       stMask,
    output memAccessPkg::word_t                           stData,

    output coreSeqPkg::storeSqN_t                         maxStoreSqN,
    output logic                                          empty
);

    // storeSqN of the oldest store still in the queue
    coreSeqPkg::storeSqN_t headSqN;

    assign headIdx = headSqN[`SQ_SLOT_W-1:0];

    // The head leaves once it is committed and has its address
    assign deqValid = entryValid[headIdx] && entryReady[headIdx] && entryAddrAvail[headIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            headSqN <= '0;
            stValid <= 1'b0;
            maxStoreSqN <= coreSeqPkg::storeSqN_t'(`SQ_ENTRIES - 1);
            empty <= 1'b1;
        end else begin
            stValid <= deqValid;
            if (deqValid) begin
                headSqN <= coreSeqPkg::storeSqN_t'(headSqN + 1'b1);
            end

            // Status lags the head by one cycle
            maxStoreSqN <= coreSeqPkg::storeSqN_t'(headSqN + (`SQ_ENTRIES - 1));
            empty <= ~|entryValid;
        end
    end

    // Store payload
    always_ff @(posedge clk) begin
        if (deqValid) begin
            stAddr <= entryAddr[headIdx];
            stMask <= entryMask[headIdx];
            stData <= entryData[headIdx];
        end
    end

endmodule

/* design/sqForward.sv */
`include "sq_consts.svh"

module sqForward (
    input  logic                                          clk,
    input  logic                                          rst,

    input  logic                                          loadValid,
    input  memAccessPkg::byteAddr_t                       loadAddr,
    input  memAccessPkg::accessSize_t                     loadSize,
    input  coreSeqPkg::sqN_t                              loadSqN,

    input  coreSeqPkg::slotIdx_t                          headIdx,

    input  logic [`SQ_ENTRIES-1:0]                        entryValid,
    input  logic [`SQ_ENTRIES-1:0]                        entryReady,
    input  logic [`SQ_ENTRIES-1:0]                        entryAddrAvail,
    input  coreSeqPkg::sqN_t [`SQ_ENTRIES-1:0]            entrySqN,
    input  memAccessPkg::wordAddr_t [`SQ_ENTRIES-1:0]     entryAddr,
    input  memAccessPkg::byteMask_t [`SQ_ENTRIES-1:0]     entryMask,
    input  memAccessPkg::word_t [`SQ_ENTRIES-1:0]         entryData,

    output logic                                          fwdValid,
    output memAccessPkg::word_t                           fwdData,
    output memAccessPkg::byteMask_t                       fwdMask
);

    memAccessPkg::wordAddr_t loadWord;
    memAccessPkg::byteMask_t readMask;
    logic [`SQ_ENTRIES-1:0] hit;
    memAccessPkg::word_t lookupData;
    memAccessPkg::byteMask_t lookupMask;

    assign loadWord = loadAddr[`XLEN-1:2];
    assign readMask = memAccessPkg::byteMaskOf(loadAddr[1:0], loadSize);

    // Stores older than the load, or already committed, to the same word
    always_comb begin
        for (int i = 0; i < `SQ_ENTRIES; i++) begin
            hit[i] = entryValid[i] && entryAddrAvail[i] && entryAddr[i] == loadWord &&
                     ($signed(coreSeqPkg::sqN_t'(entrySqN[i] - loadSqN)) < 0 ||
                      entryReady[i]);
        end
    end

    // Walk from the head toward the tail so the youngest store wins each byte
    always_comb begin
        coreSeqPkg::slotIdx_t idx;
        lookupData = '0;
        lookupMask = ~readMask;
        for (int i = 0; i < `SQ_ENTRIES; i++) begin
            idx = coreSeqPkg::slotIdx_t'(headIdx + i);
            if (hit[idx]) begin
                for (int b = 0; b < 4; b++) begin
                    if (entryMask[idx][b]) begin
                        lookupData[b*8 +: 8] = entryData[idx][b*8 +: 8];
                    end
                end
                lookupMask = lookupMask | entryMask[idx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fwdValid <= 1'b0;
        end else begin
            fwdValid <= loadValid;
        end
    end

    always_ff @(posedge clk) begin
        if (loadValid) begin
            fwdData <= lookupData;
            fwdMask <= lookupMask;
        end
    end

endmodule

/* design/storeQueue.sv */
`include "sq_consts.svh"

module storeQueue (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          enqValid,
    input  coreSeqPkg::sqN_t              enqSqN,
    input  coreSeqPkg::storeSqN_t         enqStoreSqN,

    input  logic                          addrValid,
    input  coreSeqPkg::storeSqN_t         addrStoreSqN,
    input  memAccessPkg::byteAddr_t       addrByte,
    input  memAccessPkg::accessSize_t     addrSize,
    input  memAccessPkg::word_t           addrData,

    input  coreSeqPkg::sqN_t              curSqN,

    input  logic                          branchValid,
    input  coreSeqPkg::sqN_t              branchSqN,

    input  logic                          loadValid,
    input  memAccessPkg::byteAddr_t       loadAddr,
    input  memAccessPkg::accessSize_t     loadSize,
    input  coreSeqPkg::sqN_t              loadSqN,

    output logic                          stValid,
    output memAccessPkg::wordAddr_t       stAddr,
    output memAccessPkg::byteMask_t       stMask,
    output memAccessPkg::word_t           stData,

    output logic                          fwdValid,
    output memAccessPkg::word_t           fwdData,
    output memAccessPkg::byteMask_t       fwdMask,

    output coreSeqPkg::storeSqN_t         maxStoreSqN,
    output logic                          empty
);

    // Slot state shared by retire and forwarding
    logic [`SQ_ENTRIES-1:0] entryValid;
    logic [`SQ_ENTRIES-1:0] entryReady;
    logic [`SQ_ENTRIES-1:0] entryAddrAvail;
    coreSeqPkg::sqN_t [`SQ_ENTRIES-1:0] entrySqN;
    memAccessPkg::wordAddr_t [`SQ_ENTRIES-1:0] entryAddr;
    memAccessPkg::byteMask_t [`SQ_ENTRIES-1:0] entryMask;
    memAccessPkg::word_t [`SQ_ENTRIES-1:0] entryData;

    coreSeqPkg::slotIdx_t headIdx;
    logic deqValid;

    sqEntryTable entryTable (
        .clk            (clk),
        .rst            (rst),
        .enqValid       (enqValid),
        .enqSqN         (enqSqN),
        .enqStoreSqN    (enqStoreSqN),
        .addrValid      (addrValid),
        .addrStoreSqN   (addrStoreSqN),
        .addrByte       (addrByte),
        .addrSize       (addrSize),
        .addrData       (addrData),
        .curSqN         (curSqN),
        .branchValid    (branchValid),
        .branchSqN      (branchSqN),
        .deqValid       (deqValid),
        .headIdx        (headIdx),
        .entryValid     (entryValid),
        .entryReady     (entryReady),
        .entryAddrAvail (entryAddrAvail),
        .entrySqN       (entrySqN),
        .entryAddr      (entryAddr),
        .entryMask      (entryMask),
        .entryData      (entryData)
    );

    sqRetire retireUnit (
        .clk            (clk),
        .rst            (rst),
        .entryValid     (entryValid),
        .entryReady     (entryReady),
        .entryAddrAvail (entryAddrAvail),
        .entryAddr      (entryAddr),
        .entryMask      (entryMask),
        .entryData      (entryData),
        .headIdx        (headIdx),
        .deqValid       (deqValid),
        .stValid        (stValid),
        .stAddr         (stAddr),
        .stMask         (stMask),
        .stData         (stData),
        .maxStoreSqN    (maxStoreSqN),
        .empty          (empty)
    );

    sqForward forwardUnit (
        .clk            (clk),
        .rst            (rst),
        .loadValid      (loadValid),
        .loadAddr       (loadAddr),
        .loadSize       (loadSize),
        .loadSqN        (loadSqN),
        .headIdx        (headIdx),
        .entryValid     (entryValid),
        .entryReady     (entryReady),
        .entryAddrAvail (entryAddrAvail),
        .entrySqN       (entrySqN),
        .entryAddr      (entryAddr),
        .entryMask      (entryMask),
        .entryData      (entryData),
        .fwdValid       (fwdValid),
        .fwdData        (fwdData),
        .fwdMask        (fwdMask)
    );

endmodule

/* bench/sqTbPkg.sv */
package sqTbPkg;

    timeunit 1ns;
    timeprecision 100ps;

    // Fibonacci LFSR state, taps 16 14 13 11
    logic [15:0] lfsrState = 16'd2147;

    // One LFSR step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // Byte, halfword or word, never the unused code 3
    function automatic logic [1:0] randSize();
        logic [1:0] s;
        s = randBits(2);
        if (s == 2'd3) begin
            s = 2'd2;
        end
        return s;
    endfunction

    // Lanes touched by an access of the given size at the given low address bits
    function automatic logic [3:0] laneMask(input logic [1:0] low, input logic [1:0] size);
        if (size == 2'd0) begin
            return 4'b0001 << low;
        end else if (size == 2'd1) begin
            return low[1] ? 4'b1100 : 4'b0011;
        end
        return 4'b1111;
    endfunction

    // Widen a lane mask to a bit mask over the word
    function automatic logic [31:0] laneBits(input logic [3:0] mask);
        return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    endfunction

endpackage

/* bench/tbStoreQueue.sv */
`include "sq_consts.svh"

module tbStoreQueue;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int numOps = 2000;

    logic clk;
    logic rst;
    logic enqValid;
    coreSeqPkg::sqN_t enqSqN;
    coreSeqPkg::storeSqN_t enqStoreSqN;
    logic addrValid;
    coreSeqPkg::storeSqN_t addrStoreSqN;
    memAccessPkg::byteAddr_t addrByte;
    memAccessPkg::accessSize_t addrSize;
    memAccessPkg::word_t addrData;
    coreSeqPkg::sqN_t curSqN;
    logic branchValid;
    coreSeqPkg::sqN_t branchSqN;
    logic loadValid;
    memAccessPkg::byteAddr_t loadAddr;
    memAccessPkg::accessSize_t loadSize;
    coreSeqPkg::sqN_t loadSqN;
    logic stValid;
    memAccessPkg::wordAddr_t stAddr;
    memAccessPkg::byteMask_t stMask;
    memAccessPkg::word_t stData;
    logic fwdValid;
    memAccessPkg::word_t fwdData;
    memAccessPkg::byteMask_t fwdMask;
    coreSeqPkg::storeSqN_t maxStoreSqN;
    logic empty;

    // Slot model as it stands after the latest edge
    logic [`SQ_ENTRIES-1:0] mValid;
    logic [`SQ_ENTRIES-1:0] mReady;
    logic [`SQ_ENTRIES-1:0] mAddrAv;
    coreSeqPkg::sqN_t mSqN [`SQ_ENTRIES];
    logic [`XLEN-3:0] mWord [`SQ_ENTRIES];
    logic [3:0] mMask [`SQ_ENTRIES];
    logic [`XLEN-1:0] mData [`SQ_ENTRIES];
    coreSeqPkg::storeSqN_t mHead;

    // Program order counters on the producer side
    coreSeqPkg::sqN_t nextSqN;
    coreSeqPkg::storeSqN_t nextStoreSqN;

    // Outputs expected after the coming edge
    logic expSt;
    logic [`XLEN-3:0] expStWord;
    logic [3:0] expStMask;
    logic [`XLEN-1:0] expStData;
    logic expFwd;
    logic [3:0] expFwdMask;
    logic [3:0] expCover;
    logic [`XLEN-1:0] expFwdData;
    coreSeqPkg::storeSqN_t expMax;
    logic expEmpty;

    // Head slot and commit number in force before the coming edge
    logic retValid;
    logic retAddrAv;
    coreSeqPkg::sqN_t retSqN;
    coreSeqPkg::sqN_t retCommit;

    storeQueue dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(numOps * 20 * 8);
        $display("Timeout: the store queue did not drain within the allowed time");
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Finished with errors");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic checkOutputs();
        // A store on the bus must have been committed and addressed before it left
        if (stValid === 1'b1) begin
            checkValue("retired store valid", retValid, 1'b1);
            checkValue("retired store addressed", retAddrAv, 1'b1);
            checkValue("retired store older than commit point",
                       $signed(coreSeqPkg::sqN_t'(retCommit - retSqN)) > 0, 1'b1);
        end
        checkValue("stValid", stValid, expSt);
        if (expSt) begin
            checkValue("stAddr", stAddr, expStWord);
            checkValue("stMask", stMask, expStMask);
            checkValue("stData", stData, expStData);
        end
        checkValue("fwdValid", fwdValid, expFwd);
        if (expFwd) begin
            checkValue("fwdMask", fwdMask, expFwdMask);
            checkValue("fwdData", fwdData & sqTbPkg::laneBits(expCover), expFwdData);
        end
        checkValue("maxStoreSqN", maxStoreSqN, expMax);
        checkValue("empty", empty, expEmpty);
    endtask

    // Check the last edge, drive the next one and step the model across it
    task automatic runCycle(input bit stimOn);
        coreSeqPkg::slotIdx_t h;
        coreSeqPkg::slotIdx_t idx;
        logic [`SQ_ENTRIES-1:0] oldReady;
        logic [3:0] readMask;
        int gap;
        int cnt;
        @(posedge clk);
        #1;
        checkOutputs();
        enqValid = 1'b0;
        addrValid = 1'b0;
        branchValid = 1'b0;
        loadValid = 1'b0;
        h = mHead[`SQ_SLOT_W-1:0];
        gap = int'(coreSeqPkg::sqN_t'(nextSqN - curSqN));

        // Head as it stands now, for the eligibility check after the edge
        retValid = mValid[h];
        retAddrAv = mAddrAv[h];
        retSqN = mSqN[h];
        retCommit = curSqN;

        // A branch between the commit point and the youngest store, alone in its cycle
        if (stimOn && gap != 0 && sqTbPkg::randBits(4) == 0) begin
            branchValid = 1'b1;
            branchSqN = coreSeqPkg::sqN_t'(curSqN + sqTbPkg::randBits(7) % gap);
        end else begin
            if (gap != 0 && (!stimOn || sqTbPkg::randBits(1))) begin
                curSqN = coreSeqPkg::sqN_t'(curSqN + 1);
            end
            if (stimOn && sqTbPkg::randBits(1) &&
                int'(coreSeqPkg::storeSqN_t'(nextStoreSqN - mHead)) < `SQ_ENTRIES) begin
                enqValid = 1'b1;
                enqSqN = nextSqN;
                enqStoreSqN = nextStoreSqN;
                nextSqN = coreSeqPkg::sqN_t'(nextSqN + 1 + sqTbPkg::randBits(1));
                nextStoreSqN = coreSeqPkg::storeSqN_t'(nextStoreSqN + 1);
            end
            // Address write to some enqueued store still without one
            idx = coreSeqPkg::slotIdx_t'(sqTbPkg::randBits(3));
            if (sqTbPkg::randBits(2) != 0) begin
                for (int i = 0; i < `SQ_ENTRIES; i++) begin
                    if (!addrValid && mValid[idx] && !mAddrAv[idx]) begin
                        addrValid = 1'b1;
                    end else if (!addrValid) begin
                        idx = coreSeqPkg::slotIdx_t'(idx + 1);
                    end
                end
            end
            if (addrValid) begin
                addrStoreSqN = coreSeqPkg::storeSqN_t'(mHead +
                                                       coreSeqPkg::slotIdx_t'(idx - h));
                addrByte = 32'h1000 + sqTbPkg::randBits(4);
                addrSize = sqTbPkg::randSize();
                addrData = sqTbPkg::randBits(32);
            end
            if (sqTbPkg::randBits(1)) begin
                loadValid = 1'b1;
                loadAddr = 32'h1000 + sqTbPkg::randBits(4);
                loadSize = sqTbPkg::randSize();
                loadSqN = coreSeqPkg::sqN_t'(curSqN - 8 + sqTbPkg::randBits(5));
            end
        end

        // Retire of the head if committed and addressed
        expSt = mValid[h] && mReady[h] && mAddrAv[h];
        if (expSt) begin
            expStWord = mWord[h];
            expStMask = mMask[h];
            expStData = mData[h];
        end
        expMax = coreSeqPkg::storeSqN_t'(mHead + `SQ_ENTRIES - 1);
        expEmpty = (mValid == '0);

        // Forwarding, oldest first so younger stores overwrite
        expFwd = loadValid;
        if (loadValid) begin
            readMask = sqTbPkg::laneMask(loadAddr[1:0], loadSize);
            expCover = '0;
            expFwdData = '0;
            for (int i = 0; i < `SQ_ENTRIES; i++) begin
                idx = coreSeqPkg::slotIdx_t'(h + i);
                if (mValid[idx] && mAddrAv[idx] && mWord[idx] == loadAddr[`XLEN-1:2] &&
                    ($signed(coreSeqPkg::sqN_t'(mSqN[idx] - loadSqN)) < 0 || mReady[idx])) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mMask[idx][b]) begin
                            expFwdData[b*8 +: 8] = mData[idx][b*8 +: 8];
                        end
                    end
                    expCover = expCover | mMask[idx];
                end
            end
            expFwdMask = expCover | ~readMask;
        end

        // Model update for the coming edge
        oldReady = mReady;
        for (int i = 0; i < `SQ_ENTRIES; i++) begin
            if (mValid[i] && $signed(coreSeqPkg::sqN_t'(curSqN - mSqN[i])) > 0) begin
                mReady[i] = 1'b1;
            end
            if (branchValid && !oldReady[i] &&
                $signed(coreSeqPkg::sqN_t'(mSqN[i] - branchSqN)) > 0) begin
                mValid[i] = 1'b0;
                mAddrAv[i] = 1'b0;
            end
        end
        if (expSt) begin
            mValid[h] = 1'b0;
            mReady[h] = 1'b0;
            mAddrAv[h] = 1'b0;
            mHead = coreSeqPkg::storeSqN_t'(mHead + 1);
        end
        if (addrValid) begin
            idx = addrStoreSqN[`SQ_SLOT_W-1:0];
            mAddrAv[idx] = 1'b1;
            mWord[idx] = addrByte[`XLEN-1:2];
            mMask[idx] = sqTbPkg::laneMask(addrByte[1:0], addrSize);
            mData[idx] = addrData << (8 * addrByte[1:0]);
        end
        if (enqValid) begin
            idx = enqStoreSqN[`SQ_SLOT_W-1:0];
            mValid[idx] = 1'b1;
            mReady[idx] = 1'b0;
            mAddrAv[idx] = 1'b0;
            mSqN[idx] = enqSqN;
        end
        // Producer rewinds to just past the youngest survivor
        if (branchValid) begin
            cnt = 0;
            while (cnt < `SQ_ENTRIES && mValid[coreSeqPkg::slotIdx_t'(mHead + cnt)]) begin
                cnt++;
            end
            nextStoreSqN = coreSeqPkg::storeSqN_t'(mHead + cnt);
            nextSqN = coreSeqPkg::sqN_t'(branchSqN + 1);
        end
    endtask

    initial begin
        rst = 1'b1;
        enqValid = 1'b0;
        enqSqN = '0;
        enqStoreSqN = '0;
        addrValid = 1'b0;
        addrStoreSqN = '0;
        addrByte = '0;
        addrSize = '0;
        addrData = '0;
        curSqN = '0;
        branchValid = 1'b0;
        branchSqN = '0;
        loadValid = 1'b0;
        loadAddr = '0;
        loadSize = '0;
        loadSqN = '0;
        mValid = '0;
        mReady = '0;
        mAddrAv = '0;
        for (int i = 0; i < `SQ_ENTRIES; i++) begin
            mSqN[i] = '0;
            mWord[i] = '0;
            mMask[i] = '0;
            mData[i] = '0;
        end
        mHead = '0;
        nextSqN = '0;
        nextStoreSqN = '0;
        expSt = 1'b0;
        expFwd = 1'b0;
        expCover = '0;
        expMax = coreSeqPkg::storeSqN_t'(`SQ_ENTRIES - 1);
        expEmpty = 1'b1;
        retValid = 1'b0;
        retAddrAv = 1'b0;
        retSqN = '0;
        retCommit = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        checkOutputs();
        repeat (numOps) runCycle(1'b1);
        // Drain with commits and address writes until the queue is empty
        while (!(mValid == '0 && expEmpty)) begin
            runCycle(1'b0);
        end
        runCycle(1'b0);
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
design/coreSeqPkg.sv
design/memAccessPkg.sv
design/sqEntryTable.sv
design/sqRetire.sv
design/sqForward.sv
design/storeQueue.sv
bench/sqTbPkg.sv
bench/tbStoreQueue.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tbStoreQueue
FILELIST = compile.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the store queue testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || { echo "Simulation incomplete"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
